// ==== include/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

`define DATA_W      32              // general register and pc width
`define REG_ADDR_W  5               // 32 general registers

//////////////////////////////
// fixed values
//////////////////////////////

`define RESET_PC    32'hbfc00000    // boot rom entry
`define LINK_REG    5'd31           // ra, written by jal and the link branches

// one bypass unit per source operand, rs and rt
`define NUM_SRC     2

`endif

// ==== logic/decode_pkg.sv ====
`include "decode_params.svh"

package decode_pkg;

    //////////////////////////////
    // scalar types
    //////////////////////////////

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // operation handed to the execute stage
    typedef enum logic [2:0] {
        alu_add    = 3'd0,          // also loads, stores, addi/addiu
        alu_and    = 3'd1,
        alu_r_type = 3'd2,          // exe decodes func itself
        alu_slt    = 3'd3,
        alu_sltu   = 3'd4,
        alu_lui    = 3'd5,
        alu_or     = 3'd6,
        alu_xor    = 3'd7
    } alu_op_e;

    //////////////////////////////
    // instruction word views
    //////////////////////////////

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] func;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;       // also the branch offset
        } i;
        struct packed {
            logic [5:0]  op;
            logic [25:0] index;     // j/jal target index
        } j;
    } inst_word_u;

endpackage

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module inst_decoder (
    input  decode_pkg::inst_word_u inst,
    output decode_pkg::reg_addr_t  rf_raddr1,
    output decode_pkg::reg_addr_t  rf_raddr2,
    output decode_pkg::reg_addr_t  dest,
    output decode_pkg::alu_op_e    alu_op,
    output logic                   is_rtype,
    output logic                   uses_rt,
    output logic                   is_zero_ext,
    output logic                   is_bneq,
    output logic                   is_bgtlez,
    output logic                   is_bgeltz,
    output logic                   is_j,
    output logic                   is_jr,
    output logic                   saveal,
    output logic                   signed_op,
    output logic                   inst_known
);

    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] func;

    logic r_nosa;                   // R-type with sa field clear
    logic r_nors;                   // R-type with rs field clear
    logic is_add, is_addu, is_sub, is_subu;
    logic is_slt, is_sltu;
    logic is_and, is_or, is_xor, is_nor;
    logic is_sllv, is_srlv, is_srav;
    logic is_sll, is_srl, is_sra;
    logic is_jalr, is_jr_only;
    logic is_addi, is_addiu, is_slti, is_sltiu;
    logic is_andi, is_ori, is_xori, is_lui;
    logic is_load, is_store;
    logic alu_rtype, shift_rtype;

    assign op   = inst.r.op;
    assign rs   = inst.r.rs;
    assign rt   = inst.r.rt;
    assign rd   = inst.r.rd;
    assign sa   = inst.r.sa;
    assign func = inst.r.func;

    //////////////////////////////
    // R-type patterns
    //////////////////////////////

    assign r_nosa  = (op == 6'b000000) && (sa == 5'd0);
    assign r_nors  = (op == 6'b000000) && (rs == 5'd0);

    assign is_add  = r_nosa && (func == 6'b100000);
    assign is_addu = r_nosa && (func == 6'b100001);
    assign is_sub  = r_nosa && (func == 6'b100010);
    assign is_subu = r_nosa && (func == 6'b100011);
    assign is_and  = r_nosa && (func == 6'b100100);
    assign is_or   = r_nosa && (func == 6'b100101);
    assign is_xor  = r_nosa && (func == 6'b100110);
    assign is_nor  = r_nosa && (func == 6'b100111);
    assign is_slt  = r_nosa && (func == 6'b101010);
    assign is_sltu = r_nosa && (func == 6'b101011);
    assign is_sllv = r_nosa && (func == 6'b000100);
    assign is_srlv = r_nosa && (func == 6'b000110);
    assign is_srav = r_nosa && (func == 6'b000111);
    assign is_sll  = r_nors && (func == 6'b000000);     // all zero word is the nop
    assign is_srl  = r_nors && (func == 6'b000010);
    assign is_sra  = r_nors && (func == 6'b000011);

    assign is_jalr    = r_nosa && (rt == 5'd0) && (func == 6'b001001);
    assign is_jr_only = r_nosa && (rt == 5'd0) && (rd == 5'd0) && (func == 6'b001000);

    assign alu_rtype   = is_add || is_addu || is_sub || is_subu || is_and || is_or
                       || is_xor || is_nor || is_slt || is_sltu;
    assign shift_rtype = is_sllv || is_srlv || is_srav || is_sll || is_srl || is_sra;

    //////////////////////////////
    // I-type and J-type patterns
    //////////////////////////////

    assign is_addi  = (op == 6'b001000);
    assign is_addiu = (op == 6'b001001);
    assign is_slti  = (op == 6'b001010);
    assign is_sltiu = (op == 6'b001011);
    assign is_andi  = (op == 6'b001100);
    assign is_ori   = (op == 6'b001101);
    assign is_xori  = (op == 6'b001110);
    assign is_lui   = (op == 6'b001111) && (rs == 5'd0);

    assign is_load  = (op[5:3] == 3'b100) && (op[2:0] != 3'b111);
    assign is_store = (op[5:2] == 4'b1010) || (op == 6'b101110);  // sb sh swl sw, swr

    assign is_bneq   = (op[5:1] == 5'b00010);                     // beq bne
    assign is_bgtlez = (op[5:1] == 5'b00011) && (rt == 5'd0);     // blez bgtz
    assign is_bgeltz = (op == 6'b000001) && (rt[3:1] == 3'b000);  // bltz bgez and link forms
    assign is_j      = (op[5:1] == 5'b00001);                     // j jal
    assign is_jr     = is_jr_only || is_jalr;

    //////////////////////////////
    // class flags and outputs
    //////////////////////////////

    assign is_rtype    = (op == 6'b000000);
    assign uses_rt     = is_rtype || is_bneq || is_store;
    assign is_zero_ext = is_andi || is_ori || is_xori;
    assign signed_op   = is_add || is_addi || is_sub;
    assign saveal      = (op == 6'b000011) || (is_bgeltz && rt[4]) || is_jalr;

    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;

    // jalr keeps its rd, normally 31
    assign dest = is_rtype ? rd :
                  saveal   ? `LINK_REG :
                             rt;

    always_comb begin
        if (is_rtype)
            alu_op = decode_pkg::alu_r_type;
        else if (is_load || is_store || is_addi || is_addiu)
            alu_op = decode_pkg::alu_add;
        else if (is_slti)
            alu_op = decode_pkg::alu_slt;
        else if (is_sltiu)
            alu_op = decode_pkg::alu_sltu;
        else if (is_lui)
            alu_op = decode_pkg::alu_lui;
        else if (is_andi)
            alu_op = decode_pkg::alu_and;
        else if (is_ori)
            alu_op = decode_pkg::alu_or;
        else if (is_xori)
            alu_op = decode_pkg::alu_xor;
        else
            alu_op = decode_pkg::alu_r_type;    // branches and jumps
    end

    assign inst_known = alu_rtype || shift_rtype || is_jr
                      || is_addi || is_addiu || is_slti || is_sltiu
                      || is_andi || is_ori || is_xori || is_lui
                      || is_load || is_store
                      || is_bneq || is_bgtlez || is_bgeltz || is_j;

endmodule

// ==== logic/operand_forward.sv ====
`timescale 1ns/1ps

module operand_forward (
    input  decode_pkg::reg_addr_t raddr,
    input  decode_pkg::word_t     rf_rdata,
    input  logic                  exe_wen,
    input  logic                  mem_wen,
    input  logic                  wb_wen,
    input  logic                  exe_ready,
    input  logic                  mem_ready,
    input  decode_pkg::reg_addr_t exe_dest,
    input  decode_pkg::reg_addr_t mem_dest,
    input  decode_pkg::reg_addr_t wb_dest,
    input  decode_pkg::word_t     exe_value,
    input  decode_pkg::word_t     mem_value,
    input  decode_pkg::word_t     wb_value,
    output decode_pkg::word_t     value,
    output logic                  hazard
);

    logic exe_hit;
    logic mem_hit;
    logic wb_hit;

    // r0 is never written, so never bypassed
    assign exe_hit = exe_wen && (exe_dest != '0) && (exe_dest == raddr);
    assign mem_hit = mem_wen && (mem_dest != '0) && (mem_dest == raddr);
    assign wb_hit  = wb_wen  && (wb_dest  != '0) && (wb_dest  == raddr);

    always_comb begin
        value  = rf_rdata;
        hazard = 1'b0;
        if (exe_hit) begin              // youngest result wins
            value  = exe_value;
            hazard = !exe_ready;        // load still in flight
        end else if (mem_hit) begin
            value  = mem_value;
            hazard = !mem_ready;
        end else if (wb_hit) begin
            value  = wb_value;          // wb is always ready
        end

        a_no_r0_hazard: assert (raddr != '0 || !hazard)
            else $error("bypass hazard raised on register 0");
    end

endmodule

// ==== logic/operand_branch_select.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module operand_branch_select (
    input  decode_pkg::inst_word_u inst,
    input  decode_pkg::word_t      pc,
    input  decode_pkg::word_t      fwd_value0,
    input  decode_pkg::word_t      fwd_value1,
    input  logic                   fwd_hazard0,
    input  logic                   fwd_hazard1,
    input  logic                   is_rtype,
    input  logic                   uses_rt,
    input  logic                   is_zero_ext,
    input  logic                   is_bneq,
    input  logic                   is_bgtlez,
    input  logic                   is_bgeltz,
    input  logic                   is_j,
    input  logic                   is_jr,
    output decode_pkg::word_t      vsrc1,
    output decode_pkg::word_t      vsrc2,
    output decode_pkg::word_t      st_value,
    output decode_pkg::word_t      br_target,
    output logic                   br_taken,
    output logic                   br_is_br,
    output logic                   br_is_j,
    output logic                   br_is_jr,
    output logic                   de_block,
    output logic [15:0]            br_offset,
    output logic [25:0]            br_index
);

    decode_pkg::word_t sext_imm;
    decode_pkg::word_t zext_imm;
    logic              equal;
    logic              gez;
    logic              gtz;

    assign sext_imm = {{(`DATA_W-16){inst.i.imm[15]}}, inst.i.imm};
    assign zext_imm = {{(`DATA_W-16){1'b0}}, inst.i.imm};

    //////////////////////////////
    // source values
    //////////////////////////////

    assign vsrc1    = fwd_value0;
    assign vsrc2    = is_rtype    ? fwd_value1 :
                      is_zero_ext ? zext_imm   :
                                    sext_imm;
    assign st_value = fwd_value1;

    //////////////////////////////
    // branch resolution
    //////////////////////////////

    assign equal = (fwd_value0 == fwd_value1);
    assign gez   = !fwd_value0[`DATA_W-1];
    assign gtz   = gez && (fwd_value0 != '0);

    // op bit 0 picks bne/bgtz, rt bit 0 picks bgez
    assign br_taken = (is_bneq   && (equal ^ inst.i.op[0]))
                   || (is_bgeltz && !(gez ^ inst.i.rt[0]))
                   || (is_bgtlez && !(gtz ^ inst.i.op[0]));

    assign br_is_br  = is_bneq || is_bgtlez || is_bgeltz;
    assign br_is_j   = is_j;
    assign br_is_jr  = is_jr;
    assign br_offset = inst.i.imm;
    assign br_index  = inst.j.index;
    assign br_target = fwd_value0;      // register target, fetch forms the others

    always_comb begin
        a_one_branch_kind: assert ($isunknown({br_is_br, br_is_j, br_is_jr})
                                   || $onehot0({br_is_br, br_is_j, br_is_jr}))
            else $error("more than one branch kind decoded");
    end

    assign de_block = fwd_hazard0 || (uses_rt && fwd_hazard1);

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  resetn,
    input  decode_pkg::word_t     fe_inst,
    input  decode_pkg::word_t     fe_pc,
    input  logic                  hold,             // external back-pressure
    input  decode_pkg::word_t     rf_rdata1,
    input  decode_pkg::word_t     rf_rdata2,
    input  logic                  exe_wen,
    input  decode_pkg::reg_addr_t exe_dest,
    input  decode_pkg::word_t     exe_value,
    input  logic                  exe_ready,
    input  logic                  mem_wen,
    input  decode_pkg::reg_addr_t mem_dest,
    input  decode_pkg::word_t     mem_value,
    input  logic                  mem_ready,
    input  logic                  wb_wen,
    input  decode_pkg::reg_addr_t wb_dest,
    input  decode_pkg::word_t     wb_value,
    output decode_pkg::word_t     de_inst,
    output decode_pkg::word_t     de_pc,
    output decode_pkg::reg_addr_t rf_raddr1,
    output decode_pkg::reg_addr_t rf_raddr2,
    output decode_pkg::reg_addr_t de_dest,
    output decode_pkg::alu_op_e   de_out_op,
    output decode_pkg::word_t     de_vsrc1,
    output decode_pkg::word_t     de_vsrc2,
    output decode_pkg::word_t     de_st_value,
    output logic                  de_signed_op,
    output logic                  de_saveal,
    output logic                  de_inst_known,
    output logic                  br_taken,
    output logic                  br_is_br,
    output logic                  br_is_j,
    output logic                  br_is_jr,
    output logic [15:0]           br_offset,
    output logic [25:0]           br_index,
    output decode_pkg::word_t     br_target,
    output logic                  de_block
);

    decode_pkg::inst_word_u inst_view;
    decode_pkg::reg_addr_t  src_addr  [`NUM_SRC];
    decode_pkg::word_t      src_rdata [`NUM_SRC];
    decode_pkg::word_t      fwd_value [`NUM_SRC];
    logic [`NUM_SRC-1:0]    fwd_hazard;
    logic                   is_rtype, uses_rt, is_zero_ext;
    logic                   is_bneq, is_bgtlez, is_bgeltz, is_j, is_jr;

    //////////////////////////////
    // instruction and pc register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            de_inst <= '0;              // sll nop
            de_pc   <= `RESET_PC;
        end else if (!(de_block || hold)) begin
            de_inst <= fe_inst;
            de_pc   <= fe_pc;
        end
    end

    assign inst_view = de_inst;

    inst_decoder i_dec (
        .inst(inst_view), .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .dest(de_dest), .alu_op(de_out_op), .is_rtype(is_rtype), .uses_rt(uses_rt),
        .is_zero_ext(is_zero_ext), .is_bneq(is_bneq), .is_bgtlez(is_bgtlez),
        .is_bgeltz(is_bgeltz), .is_j(is_j), .is_jr(is_jr), .saveal(de_saveal),
        .signed_op(de_signed_op), .inst_known(de_inst_known)
    );

    // rs feeds unit 0, rt feeds unit 1
    assign src_addr[0]  = rf_raddr1;
    assign src_addr[1]  = rf_raddr2;
    assign src_rdata[0] = rf_rdata1;
    assign src_rdata[1] = rf_rdata2;

    for (genvar g = 0; g < `NUM_SRC; g++) begin : g_fwd
        operand_forward i_fwd (
            .raddr(src_addr[g]), .rf_rdata(src_rdata[g]),
            .exe_wen(exe_wen), .mem_wen(mem_wen), .wb_wen(wb_wen),
            .exe_ready(exe_ready), .mem_ready(mem_ready),
            .exe_dest(exe_dest), .mem_dest(mem_dest), .wb_dest(wb_dest),
            .exe_value(exe_value), .mem_value(mem_value), .wb_value(wb_value),
            .value(fwd_value[g]), .hazard(fwd_hazard[g])
        );
    end

    operand_branch_select i_sel (
        .inst(inst_view), .pc(de_pc),
        .fwd_value0(fwd_value[0]), .fwd_value1(fwd_value[1]),
        .fwd_hazard0(fwd_hazard[0]), .fwd_hazard1(fwd_hazard[1]),
        .is_rtype(is_rtype), .uses_rt(uses_rt), .is_zero_ext(is_zero_ext),
        .is_bneq(is_bneq), .is_bgtlez(is_bgtlez), .is_bgeltz(is_bgeltz),
        .is_j(is_j), .is_jr(is_jr),
        .vsrc1(de_vsrc1), .vsrc2(de_vsrc2), .st_value(de_st_value),
        .br_target(br_target), .br_taken(br_taken), .br_is_br(br_is_br),
        .br_is_j(br_is_j), .br_is_jr(br_is_jr), .de_block(de_block),
        .br_offset(br_offset), .br_index(br_index)
    );

    // a stall request freezes the stage on the next edge
    a_block_holds: assert property (@(posedge clk) disable iff (!resetn)
        de_block |=> ($stable(de_inst) && $stable(de_pc)))
        else $error("decode register changed during a stall");

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 resetn = 1'b1;               // released just after an edge
    end

endmodule

// ==== tb/decode_tb.sv ====
`timescale 1ns/1ps
`include "decode_params.svh"

module decode_tb;

    logic                  clk, resetn;
    decode_pkg::word_t     fe_inst, fe_pc, rf_rdata1, rf_rdata2;
    logic                  hold, exe_wen, exe_ready, mem_wen, mem_ready, wb_wen;
    decode_pkg::reg_addr_t exe_dest, mem_dest, wb_dest;
    decode_pkg::word_t     exe_value, mem_value, wb_value;
    decode_pkg::word_t     de_inst, de_pc, de_vsrc1, de_vsrc2, de_st_value, br_target;
    decode_pkg::reg_addr_t rf_raddr1, rf_raddr2, de_dest;
    decode_pkg::alu_op_e   de_out_op;
    logic                  de_signed_op, de_saveal, de_inst_known, de_block;
    logic                  br_taken, br_is_br, br_is_j, br_is_jr;
    logic [15:0]           br_offset;
    logic [25:0]           br_index;

    int                    fd, n_fields, n_tests, n_failed, test_errs;
    logic [8*256-1:0]      line_buf;
    logic [8*24-1:0]       t_name;
    logic [31:0]           v_inst, v_pc, v_rf1, v_rf2;
    logic [31:0]           v_ew, v_ed, v_ev, v_er, v_mw, v_md, v_mv, v_mr;
    logic [31:0]           v_ww, v_wd, v_wv, v_hold;
    logic [31:0]           v_dest, v_op, v_vsrc1, v_vsrc2, v_taken, v_kind, v_known, v_block;
    decode_pkg::word_t     model_inst, model_pc;    // what the stage register should hold
    logic [31:0]           rng_state;

    tb_clock #(.period_ns(8), .reset_cycles(10)) i_clk (.clk(clk), .resetn(resetn));

    decode_stage i_dut (
        .clk(clk), .resetn(resetn), .fe_inst(fe_inst), .fe_pc(fe_pc), .hold(hold),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .exe_wen(exe_wen), .exe_dest(exe_dest), .exe_value(exe_value), .exe_ready(exe_ready),
        .mem_wen(mem_wen), .mem_dest(mem_dest), .mem_value(mem_value), .mem_ready(mem_ready),
        .wb_wen(wb_wen), .wb_dest(wb_dest), .wb_value(wb_value),
        .de_inst(de_inst), .de_pc(de_pc), .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .de_dest(de_dest), .de_out_op(de_out_op), .de_vsrc1(de_vsrc1), .de_vsrc2(de_vsrc2),
        .de_st_value(de_st_value), .de_signed_op(de_signed_op), .de_saveal(de_saveal),
        .de_inst_known(de_inst_known), .br_taken(br_taken), .br_is_br(br_is_br),
        .br_is_j(br_is_j), .br_is_jr(br_is_jr), .br_offset(br_offset),
        .br_index(br_index), .br_target(br_target), .de_block(de_block)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // youngest enabled write to a nonzero register, else the register file
    function automatic decode_pkg::word_t operand_value(input decode_pkg::reg_addr_t addr,
                                                        input decode_pkg::word_t rf);
        if (v_ew[0] && v_ed[4:0] != 5'd0 && v_ed[4:0] == addr)
            return v_ev;
        if (v_mw[0] && v_md[4:0] != 5'd0 && v_md[4:0] == addr)
            return v_mv;
        if (v_ww[0] && v_wd[4:0] != 5'd0 && v_wd[4:0] == addr)
            return v_wv;
        return rf;
    endfunction

    // add, sub and addi trap on overflow
    function automatic logic overflow_trap(input decode_pkg::word_t inst);
        if (inst[31:26] == 6'b001000)
            return 1'b1;
        return (inst[31:26] == 6'b000000) && (inst[10:6] == 5'd0)
            && (inst[5:0] == 6'b100000 || inst[5:0] == 6'b100010);
    endfunction

    task automatic check_word(input string field, input decode_pkg::word_t exp,
                              input decode_pkg::word_t act);
        if (exp !== act) begin
            $display("error %0s %0s: expected %h, actual %h", t_name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_addr(input string field, input decode_pkg::reg_addr_t exp,
                              input decode_pkg::reg_addr_t act);
        if (exp !== act) begin
            $display("error %0s %0s: expected %0d, actual %0d", t_name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_op(input decode_pkg::alu_op_e exp, input decode_pkg::alu_op_e act);
        if (exp !== act) begin
            $display("error %0s alu op: expected %0d, actual %0d", t_name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string field, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error %0s %0s: expected %b, actual %b", t_name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic finish_test();
        n_tests++;
        if (test_errs != 0)
            n_failed++;
        else
            $display("%0s: ok", t_name);
    endtask

    //////////////////////////////
    // stall sequence
    //////////////////////////////

    task automatic run_stall();
        decode_pkg::word_t next_inst;
        int                n;
        rng_state = xorshift32(rng_state);
        next_inst = {6'b001101, 5'd0, rng_state[20:0]};     // ori from r0, never stalls
        @(posedge clk);
        #1 fe_inst = next_inst;
        for (n = 0; n < 3; n++) begin
            @(posedge clk);
            #4;
            check_word("stalled inst", model_inst, de_inst);
            check_bit("stalled block", 1'b1, de_block);
        end
        @(posedge clk);
        #1;
        exe_ready = 1'b1;
        mem_ready = 1'b1;
        n = 0;
        do begin
            #1;
            n++;
        end while (de_block && n < 20);
        if (de_block) begin
            $display("de_block stayed high after the producing stage became ready");
            test_errs++;
        end
        @(posedge clk);
        #4;
        check_word("inst after stall", next_inst, de_inst);
        model_inst = next_inst;
    endtask

    task automatic run_vector();
        @(posedge clk);
        #1;
        fe_inst   = v_inst;
        fe_pc     = v_pc;
        rf_rdata1 = v_rf1;
        rf_rdata2 = v_rf2;
        exe_wen   = v_ew[0];
        exe_dest  = v_ed[4:0];
        exe_value = v_ev;
        exe_ready = v_er[0];
        mem_wen   = v_mw[0];
        mem_dest  = v_md[4:0];
        mem_value = v_mv;
        mem_ready = v_mr[0];
        wb_wen    = v_ww[0];
        wb_dest   = v_wd[4:0];
        wb_value  = v_wv;
        hold      = v_hold[0];
        if (!v_hold[0]) begin
            model_inst = v_inst;
            model_pc   = v_pc;
        end
        @(posedge clk);
        #4;                                 // mid cycle, outputs settled
        test_errs = 0;
        check_word("de_inst", model_inst, de_inst);
        check_word("de_pc", model_pc, de_pc);
        check_addr("dest", v_dest[4:0], de_dest);
        check_op(decode_pkg::alu_op_e'(v_op[2:0]), de_out_op);
        check_word("vsrc1", v_vsrc1, de_vsrc1);
        check_word("vsrc2", v_vsrc2, de_vsrc2);
        check_bit("br_taken", v_taken[0], br_taken);
        check_bit("br_is_br", v_kind == 1, br_is_br);
        check_bit("br_is_j", v_kind == 2, br_is_j);
        check_bit("br_is_jr", v_kind == 3, br_is_jr);
        check_bit("inst_known", v_known[0], de_inst_known);
        check_bit("de_block", v_block[0], de_block);
        check_addr("rf_raddr1", model_inst[25:21], rf_raddr1);
        check_addr("rf_raddr2", model_inst[20:16], rf_raddr2);
        check_word("st_value", operand_value(model_inst[20:16], v_rf2), de_st_value);
        check_word("br_target", v_vsrc1, br_target);
        check_word("br_offset", {16'h0, model_inst[15:0]}, {16'h0, br_offset});
        check_word("br_index", {6'h0, model_inst[25:0]}, {6'h0, br_index});
        check_bit("signed_op", overflow_trap(model_inst), de_signed_op);
        check_bit("saveal", (v_kind != 0) && (v_dest[4:0] == `LINK_REG), de_saveal);
        if (v_block[0] && test_errs == 0)
            run_stall();
        finish_test();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int n;
        fe_inst   = '0;
        fe_pc     = '0;
        hold      = 1'b0;
        rf_rdata1 = '0;
        rf_rdata2 = '0;
        exe_wen   = 1'b0;
        exe_dest  = '0;
        exe_value = '0;
        exe_ready = 1'b1;
        mem_wen   = 1'b0;
        mem_dest  = '0;
        mem_value = '0;
        mem_ready = 1'b1;
        wb_wen    = 1'b0;
        wb_dest   = '0;
        wb_value  = '0;
        n_tests   = 0;
        n_failed  = 0;
        rng_state = 32'h3ed8a4df;

        // look at the reset state before the first capture edge
        n = 0;
        while (resetn !== 1'b1 && n < 200) begin
            #1;
            n++;
        end

        t_name    = "reset";
        test_errs = 0;
        if (resetn !== 1'b1) begin
            $display("reset was never released");
            test_errs++;
        end
        #3;
        check_word("de_inst", 32'h0, de_inst);
        check_word("de_pc", `RESET_PC, de_pc);
        check_bit("de_block", 1'b0, de_block);
        check_bit("br_taken", 1'b0, br_taken);
        check_bit("br_is_br", 1'b0, br_is_br);
        check_bit("br_is_j", 1'b0, br_is_j);
        check_bit("br_is_jr", 1'b0, br_is_jr);
        check_bit("saveal", 1'b0, de_saveal);
        finish_test();

        fd = $fopen("tb/decode_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/decode_testdata.txt");
            n_failed++;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                void'($fgets(line_buf, fd));
                n_fields = $sscanf(line_buf,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    t_name, v_inst, v_pc, v_rf1, v_rf2, v_ew, v_ed, v_ev, v_er,
                    v_mw, v_md, v_mv, v_mr, v_ww, v_wd, v_wv, v_hold,
                    v_dest, v_op, v_vsrc1, v_vsrc2, v_taken, v_kind, v_known, v_block);
                if (n_fields == 25)         // comment and blank lines fall through
                    run_vector();
            end
            $fclose(fd);
        end
        if (n_tests < 2) begin
            $display("no test vectors were read");
            n_failed++;
        end

        $display("%0d tests run, %0d failed", n_tests, n_failed);
        if (n_failed == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial begin
        #200000;
        $display("simulation timed out");
        $display("test failed");
        $finish;
    end

endmodule

// ==== tb/decode_testdata.txt ====
# name inst pc rf1 rf2 exe(wen dest value ready) mem(wen dest value ready) wb(wen dest value) hold
# then expected: dest aluop vsrc1 vsrc2 taken kind(0 none 1 br 2 j 3 jr) known block
addiu_sext 24228000 bfc00100 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 02 0 00000010 ffff8000 0 0 1 0
andi_zext 30238000 bfc00104 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 03 1 00000010 00008000 0 0 1 0
ori_zext 34241234 bfc00108 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 04 6 00000010 00001234 0 0 1 0
lui_imm 3c05abcd bfc0010c 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 05 5 00000010 ffffabcd 0 0 1 0
addu_rtype 00223021 bfc00110 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 06 2 00000010 00000020 0 0 1 0
slti_neg 2827ffff bfc00114 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 07 3 00000010 ffffffff 0 0 1 0
imm_no_rt_stall 24228000 bfc00118 00000010 00000020 1 02 77777777 0 0 00 00000000 1 0 00 00000000 0 02 0 00000010 ffff8000 0 0 1 0
sw_store ac220004 bfc0011c 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 02 0 00000010 00000004 0 0 1 0
byp_exe 00223021 bfc00120 00000010 00000020 1 01 11111111 1 1 01 22222222 1 1 01 33333333 0 06 2 11111111 00000020 0 0 1 0
byp_mem 00223021 bfc00124 00000010 00000020 0 01 11111111 1 1 01 22222222 1 1 01 33333333 0 06 2 22222222 00000020 0 0 1 0
byp_wb 00223021 bfc00128 00000010 00000020 0 01 11111111 1 0 01 22222222 1 1 01 33333333 0 06 2 33333333 00000020 0 0 1 0
byp_rt 00223021 bfc0012c 00000010 00000020 1 02 44444444 1 0 00 00000000 1 0 00 00000000 0 06 2 00000010 44444444 0 0 1 0
byp_r0 00023021 bfc00130 00000000 00000020 1 00 11111111 0 1 00 22222222 0 1 00 33333333 0 06 2 00000000 00000020 0 0 1 0
load_use_exe 00223021 bfc00134 00000010 00000020 1 01 55555555 0 0 00 00000000 1 0 00 00000000 0 06 2 55555555 00000020 0 0 1 1
load_use_mem_rt 00223021 bfc00138 00000010 00000020 0 00 00000000 1 1 02 66666666 0 0 00 00000000 0 06 2 00000010 66666666 0 0 1 1
beq_taken 10220004 bfc00200 00000005 00000005 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 02 2 00000005 00000004 1 1 1 0
beq_not 10220004 bfc00204 00000005 00000006 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 02 2 00000005 00000004 0 1 1 0
bne_taken 14220004 bfc00208 00000005 00000006 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 02 2 00000005 00000004 1 1 1 0
bgez_zero 04210004 bfc0020c 00000000 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 01 2 00000000 00000004 1 1 1 0
bltz_neg 04200004 bfc00210 ffffffff 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 ffffffff 00000004 1 1 1 0
bltz_zero 04200004 bfc00214 00000000 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 00000000 00000004 0 1 1 0
bgtz_zero 1c200004 bfc00218 00000000 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 00000000 00000004 0 1 1 0
blez_zero 18200004 bfc0021c 00000000 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 00000000 00000004 1 1 1 0
bgezal_link 04310004 bfc00220 00000001 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 1f 2 00000001 00000004 1 1 1 0
j_kind 08000040 bfc00224 00000000 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 00000000 00000040 0 2 1 0
jal_link 0c000040 bfc00228 00000000 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 1f 2 00000000 00000040 0 2 1 0
jr_kind 03e00008 bfc0022c bfc00400 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 bfc00400 00000000 0 3 1 0
jalr_link 0040f809 bfc00230 bfc00400 00000000 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 1f 2 bfc00400 00000000 0 3 1 0
bad_opcode fc000000 bfc00234 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 00000010 00000000 0 0 0 0
bad_func 00000001 bfc00238 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 00000010 00000020 0 0 0 0
hold_keep 3c05abcd bfc00300 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 1 00 2 00000010 00000020 0 0 0 0
hold_release 3c05abcd bfc00300 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 05 5 00000010 ffffabcd 0 0 1 0
nop_sll 00000000 bfc00304 00000010 00000020 0 00 00000000 1 0 00 00000000 1 0 00 00000000 0 00 2 00000010 00000020 0 0 1 0

// ==== decode_stage.f ====
+incdir+include
logic/decode_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/operand_branch_select.sv
logic/decode_stage.sv
tb/tb_clock.sv
tb/decode_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -j 0 \
    --top-module decode_tb \
    -f decode_stage.f \
    --Mdir build/obj \
    -o decode_sim

./build/obj/decode_sim | tee build/sim.log

if grep -qx "test passed" build/sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see build/sim.log"
    exit 1
fi
